//--- files.f
source/rv_pkg.sv
source/ctrl_if.sv
source/alu.sv
source/main_decoder.sv
source/alu_decoder.sv
source/register_file.sv
source/immediate_gen.sv
source/rv_core.sv
sim/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --top-module tb_rv_core -f files.f --Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_rv_core" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$log"; then
    exit 0
fi
exit 1

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    // ==================================================================
    // Instruction encodings and testbench state
    // ==================================================================

    localparam logic [6:0]  op_reg   = 7'b0110011;
    localparam logic [6:0]  op_imm   = 7'b0010011;
    localparam logic [6:0]  op_load  = 7'b0000011;
    localparam logic [6:0]  op_lui   = 7'b0110111;
    localparam logic [6:0]  op_auipc = 7'b0010111;
    localparam logic [31:0] nop      = 32'h0000_0013;    // addi x0, x0, 0.
    localparam logic [31:0] marker   = 32'h0000_05a5;

    logic        CLK = 1'b0;
    logic        RESET_N = 1'b0;
    logic [31:0] rom_q;
    logic [9:0]  rom_addr;
    logic [31:0] ram_q;
    logic [9:0]  ram_addr;
    logic [31:0] ram_wdata;
    logic        ram_we;

    logic [31:0] rom [1024];
    logic [31:0] ram [1024];
    logic [31:0] ram_init [1024];                        // copied into ram while reset is low.
    logic [9:0]  pc_idx;                                 // rom word that the next emit fills.
    logic [9:0]  slot;                                   // next free result word in ram.
    logic [9:0]  exp_idx [$];
    logic [31:0] exp_val [$];
    logic [15:0] lfsr = 16'd35352;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          total_errors = 0;

    rv_core #(.addr_width(10)) dut0 (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rom_q     (rom_q),
        .rom_addr  (rom_addr),
        .ram_q     (ram_q),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we)
    );

    always #5 CLK = ~CLK;

    assign rom_q = rom[rom_addr];
    assign ram_q = ram[ram_addr];

    always @(posedge CLK) begin
        if (!RESET_N) begin
            for (int i = 0; i < 1024; i++) begin
                ram[10'(i)] <= ram_init[10'(i)];
            end
        end else if (ram_we) begin
            ram[ram_addr] <= ram_wdata;
        end
    end

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit.
    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ==================================================================
    // Program building and running
    // ==================================================================

    task automatic emit(logic [31:0] w);
        rom[pc_idx] = w;
        pc_idx = pc_idx + 10'd1;
    endtask

    task automatic store_word(logic [4:0] rs, logic [9:0] word);
        logic [11:0] ofs;
        ofs = {word, 2'b00};                             // sw rs, ofs(x0).
        emit({ofs[11:5], rs, 5'd0, 3'b010, ofs[4:0], 7'b0100011});
    endtask

    task automatic expect_word(logic [9:0] word, logic [31:0] val);
        exp_idx.push_back(word);
        exp_val.push_back(val);
    endtask

    task automatic store_check(logic [4:0] rs, logic [31:0] val);
        store_word(rs, slot);
        expect_word(slot, val);
        slot = slot + 10'd1;
    endtask

    task automatic load_const(logic [4:0] rd, logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;                        // addi adds back a signed low part.
        emit({hi[19:0], rd, op_lui});
        emit(enc_i(v[11:0], rd, 3'b000, rd, op_imm));
    endtask

    task automatic r_op(logic [6:0] f7, logic [2:0] f3, logic [31:0] val);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_check(5'd3, val);
    endtask

    task automatic i_op(logic [11:0] imm, logic [2:0] f3, logic [31:0] val);
        emit(enc_i(imm, 5'd1, f3, 5'd3, op_imm));
        store_check(5'd3, val);
    endtask

    task automatic begin_test();
        @(posedge CLK);
        RESET_N <= 1'b0;
        @(posedge CLK);
        for (int i = 0; i < 1024; i++) begin
            rom[10'(i)] = nop;
            ram_init[10'(i)] = '0;
        end
        pc_idx = '0;
        slot = '0;
        exp_idx.delete();
        exp_val.delete();
    endtask

    task automatic finish_test(string name);
        logic [9:0] halt;
        int         cycles;
        int         errs;
        bit         reached;
        halt = pc_idx;
        emit(enc_j(21'd0, 5'd0));                        // jal x0, 0 parks the core.
        @(posedge CLK);
        RESET_N <= 1'b1;
        cycles = 0;
        errs = 0;
        reached = 1'b0;
        while (!reached && cycles < 1000) begin
            @(negedge CLK);
            cycles++;
            if (rom_addr == halt) begin
                reached = 1'b1;
            end
        end
        if (!reached) begin
            $display("%s: timeout, rom_addr never reached word %0d", name, halt);
            errs = 1;
        end else begin
            for (int k = 0; k < exp_idx.size(); k++) begin
                if (ram[exp_idx[k]] !== exp_val[k]) begin
                    $display("** Error at %0t: ram[%0d] expected %h, got %h", $time,
                             exp_idx[k], exp_val[k], ram[exp_idx[k]]);
                    errs++;
                end
            end
        end
        tests_run++;
        total_errors += errs;
        if (errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ix;
        a = 32'hf0f0_1234;
        b = 32'h0000_0f23;                               // shift amount 3.
        ix = 32'hffff_f823;                              // sign-extended 12'h823.
        begin_test();
        load_const(5'd1, a);
        load_const(5'd2, b);
        r_op(7'h00, 3'b000, a + b);
        r_op(7'h20, 3'b000, a - b);
        r_op(7'h00, 3'b001, a << 3);
        r_op(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
        r_op(7'h00, 3'b011, {31'b0, a < b});
        r_op(7'h00, 3'b100, a ^ b);
        r_op(7'h00, 3'b101, a >> 3);
        r_op(7'h20, 3'b101, $signed(a) >>> 3);
        r_op(7'h00, 3'b110, a | b);
        r_op(7'h00, 3'b111, a & b);
        i_op(12'h823, 3'b000, a + ix);
        i_op(12'h823, 3'b010, {31'b0, $signed(a) < $signed(ix)});
        i_op(12'h823, 3'b011, {31'b0, a < ix});
        i_op(12'h823, 3'b100, a ^ ix);
        i_op(12'h823, 3'b110, a | ix);
        i_op(12'h823, 3'b111, a & ix);
        i_op(12'h007, 3'b001, a << 7);
        i_op(12'h007, 3'b101, a >> 7);
        i_op(12'h407, 3'b101, $signed(a) >>> 7);
        finish_test("alu ops");
    endtask

    task automatic test_random();
        logic [31:0] x;
        logic [31:0] y;
        begin_test();
        for (int i = 0; i < 10; i++) begin
            x = rand_word();
            y = rand_word();
            load_const(5'd1, x);
            load_const(5'd2, y);
            r_op(7'h00, 3'b000, x + y);
            r_op(7'h20, 3'b000, x - y);
            r_op(7'h00, 3'b100, x ^ y);
        end
        finish_test("random arithmetic");
    endtask

    task automatic test_load_store();
        logic [31:0] orig [4];
        begin_test();
        for (int i = 0; i < 4; i++) begin
            orig[i] = rand_word();
            ram_init[10'(100 + i)] = orig[i];
            emit(enc_i(12'(400 + 4 * i), 5'd0, 3'b010, 5'd1, op_load));
            emit(enc_i(12'd77, 5'd1, 3'b000, 5'd1, op_imm));
            store_word(5'd1, 10'(120 + i));
            expect_word(10'(120 + i), orig[i] + 32'd77);
            expect_word(10'(100 + i), orig[i]);          // source words stay as loaded.
        end
        finish_test("load store");
    endtask

    task automatic test_upper();
        logic [9:0] idx;
        begin_test();
        emit({20'habcde, 5'd1, op_lui});
        store_check(5'd1, 32'habcd_e000);
        idx = pc_idx;
        emit({20'h12345, 5'd2, op_auipc});
        store_check(5'd2, {20'b0, idx, 2'b00} + 32'h1234_5000);
        idx = pc_idx;
        emit({20'hfffff, 5'd2, op_auipc});
        store_check(5'd2, {20'b0, idx, 2'b00} - 32'd4096);
        finish_test("upper immediates");
    endtask

    task automatic branch_case(logic [2:0] f3, logic [4:0] rs2, bit taken, logic [9:0] word);
        emit(enc_b(13'd8, rs2, 5'd1, f3));               // a taken branch skips one store.
        store_word(5'd4, word);
        store_word(5'd4, word + 10'd1);
        expect_word(word, taken ? 32'd0 : marker);
        expect_word(word + 10'd1, marker);
    endtask

    task automatic test_branch();
        begin_test();
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, op_imm));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, op_imm));
        emit(enc_i(marker[11:0], 5'd0, 3'b000, 5'd4, op_imm));
        branch_case(3'b000, 5'd2, 1'b1, 10'd200);
        branch_case(3'b000, 5'd3, 1'b0, 10'd202);
        branch_case(3'b001, 5'd3, 1'b1, 10'd204);
        branch_case(3'b001, 5'd2, 1'b0, 10'd206);
        finish_test("branches");
    endtask

    task automatic test_jal();
        logic [9:0] idx;
        begin_test();
        emit(enc_i(marker[11:0], 5'd0, 3'b000, 5'd4, op_imm));
        idx = pc_idx;
        emit(enc_j(21'd8, 5'd5));
        store_word(5'd4, 10'd300);
        store_word(5'd5, 10'd301);
        expect_word(10'd300, 32'd0);
        expect_word(10'd301, {20'b0, idx, 2'b00} + 32'd4);
        finish_test("jump and link");
    endtask

    initial begin
        test_alu();
        test_random();
        test_load_store();
        test_upper();
        test_branch();
        test_jal();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];                     // shifts only look at the low five bits.

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = rv_pkg::word_t'($signed(a) >>> shamt);
            rv_pkg::alu_slt: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            rv_pkg::alu_sltu: begin
                result = '0;
                result[0] = a < b;
            end
            default:          result = '0;
        endcase
    end

    // beq and bne subtract the operands and look at this flag.
    assign zero = (result == '0);

endmodule

//--- source/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    input  logic            bit30,
    output rv_pkg::alu_op_t alu_op
);

    rv_pkg::alu_op_t arith_op;

    // shared funct3 table for register and immediate arithmetic.
    always_comb begin
        case (funct3)
            3'b000:  arith_op = rv_pkg::alu_add;
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b011:  arith_op = rv_pkg::alu_sltu;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = bit30 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            default: arith_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::op_rtype: begin
                if (funct3 == 3'b000 && bit30)
                    alu_op = rv_pkg::alu_sub;
                else
                    alu_op = arith_op;
            end
            rv_pkg::op_itype: alu_op = arith_op;        // addi keeps add for any bit 30.
            rv_pkg::op_branch: alu_op = rv_pkg::alu_sub;
            default:          alu_op = rv_pkg::alu_add;  // address and pc sums.
        endcase
    end

endmodule

//--- source/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

    logic              branch;                 // beq or bne in flight.
    logic              mem_write;
    logic              reg_write;
    logic              alu_src_imm;            // operand b comes from the immediate.
    rv_pkg::src_a_t    src_a;
    rv_pkg::wb_sel_t   wb_sel;
    rv_pkg::imm_kind_t imm_kind;

    modport decoder (
        output branch, mem_write, reg_write, alu_src_imm,
        output src_a, wb_sel, imm_kind
    );

    modport datapath (
        input branch, mem_write, reg_write, alu_src_imm,
        input src_a, wb_sel, imm_kind
    );

endinterface

//--- source/immediate_gen.sv
`timescale 1ns/1ps

module immediate_gen (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::imm_kind_t kind,
    output rv_pkg::word_t     imm
);

    logic sign;

    assign sign = instr[31];                   // every format takes its sign from bit 31.

    always_comb begin
        case (kind)
            rv_pkg::imm_i: imm = {{20{sign}}, instr[31:20]};
            rv_pkg::imm_s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            rv_pkg::imm_b: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::imm_u: imm = {instr[31:12], 12'b0};
            rv_pkg::imm_j: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default:       imm = '0;
        endcase
    end

endmodule

//--- source/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
    input rv_pkg::opcode_t opcode,
    ctrl_if.decoder        ctrl
);

    always_comb begin
        // anything not listed below falls through as a no-op.
        ctrl.branch      = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.reg_write   = 1'b0;
        ctrl.alu_src_imm = 1'b0;
        ctrl.src_a       = rv_pkg::src_a_reg;
        ctrl.wb_sel      = rv_pkg::wb_alu;
        ctrl.imm_kind    = rv_pkg::imm_i;

        case (opcode)
            rv_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_itype: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            rv_pkg::op_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;       // address is rs1 plus offset.
                ctrl.wb_sel      = rv_pkg::wb_mem;
            end
            rv_pkg::op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = rv_pkg::imm_s;
            end
            rv_pkg::op_branch: begin
                ctrl.branch   = 1'b1;          // the alu compares rs1 against rs2.
                ctrl.imm_kind = rv_pkg::imm_b;
            end
            rv_pkg::op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = rv_pkg::src_a_zero;
                ctrl.imm_kind    = rv_pkg::imm_u;
            end
            rv_pkg::op_auipc: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = rv_pkg::src_a_pc;
                ctrl.imm_kind    = rv_pkg::imm_u;
            end
            rv_pkg::op_jal: begin
                // the link select also tells the core to take the jump.
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = rv_pkg::src_a_pc;
                ctrl.wb_sel      = rv_pkg::wb_link;
                ctrl.imm_kind    = rv_pkg::imm_j;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic             CLK,
    input  logic             RESET_N,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata,
    input  logic             we,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;                 // x0 is never written.
        end
    end

    // x0 reads as zero regardless of the array.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter int addr_width = 10
) (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  logic [rv_pkg::xlen-1:0] rom_q,
    output logic [addr_width-1:0]   rom_addr,
    input  logic [rv_pkg::xlen-1:0] ram_q,
    output logic [addr_width-1:0]   ram_addr,
    output logic [rv_pkg::xlen-1:0] ram_wdata,
    output logic                    ram_we
);

    // ======================================================================
    // Fetch and decode
    // ======================================================================

    rv_pkg::word_t    pc;
    rv_pkg::word_t    pc_plus4;
    rv_pkg::word_t    branch_target;
    rv_pkg::word_t    next_pc;
    rv_pkg::opcode_t  opcode;
    rv_pkg::alu_op_t  alu_op;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    rdata1;
    rv_pkg::word_t    rdata2;
    rv_pkg::word_t    op_a;
    rv_pkg::word_t    op_b;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    wb_data;
    logic             alu_zero;
    logic             pc_taken;

    ctrl_if ctrl0 ();

    assign opcode = rv_pkg::opcode_t'(rom_q[6:0]);

    main_decoder main_decoder0 (
        .opcode (opcode),
        .ctrl   (ctrl0.decoder)
    );

    alu_decoder alu_decoder0 (
        .opcode (opcode),
        .funct3 (rom_q[14:12]),
        .bit30  (rom_q[30]),
        .alu_op (alu_op)
    );

    immediate_gen immediate_gen0 (
        .instr (rom_q),
        .kind  (ctrl0.imm_kind),
        .imm   (imm)
    );

    register_file register_file0 (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (rom_q[19:15]),
        .rs2     (rom_q[24:20]),
        .rd      (rom_q[11:7]),
        .wdata   (wb_data),
        .we      (ctrl0.reg_write),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    // ======================================================================
    // Execute and write-back
    // ======================================================================

    always_comb begin
        case (ctrl0.src_a)
            rv_pkg::src_a_pc:   op_a = pc;
            rv_pkg::src_a_zero: op_a = '0;
            default:            op_a = rdata1;
        endcase
    end

    assign op_b = ctrl0.alu_src_imm ? imm : rdata2;

    alu alu0 (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb begin
        case (ctrl0.wb_sel)
            rv_pkg::wb_mem:  wb_data = ram_q;
            rv_pkg::wb_link: wb_data = pc_plus4;   // jal links to the next instruction.
            default:         wb_data = alu_result;
        endcase
    end

    assign ram_addr  = alu_result[addr_width+1:2];
    assign ram_wdata = rdata2;
    assign ram_we    = ctrl0.mem_write;

    // ======================================================================
    // Next pc
    // ======================================================================

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm;

    // funct3 bit 0 separates bne from beq.
    assign pc_taken = (ctrl0.wb_sel == rv_pkg::wb_link) ||
                      (ctrl0.branch && (rom_q[12] ? !alu_zero : alu_zero));

    assign next_pc = pc_taken ? branch_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign rom_addr = pc[addr_width+1:2];     // the rom is word addressed.

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    localparam int xlen = 32;                  // data path width of the core.

    typedef logic [xlen-1:0] word_t;           // data, instruction or immediate.
    typedef logic [4:0]      reg_idx_t;        // index into the register file.

    // ======================================================================
    // Instruction encodings
    // ======================================================================

    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,                // add, sub, and, or and the rest.
        op_itype  = 7'b0010011,                // immediate arithmetic.
        op_load   = 7'b0000011,                // only lw is decoded.
        op_store  = 7'b0100011,                // only sw is decoded.
        op_branch = 7'b1100011,                // beq and bne.
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,                       // signed compare.
        alu_sltu = 4'd9                        // unsigned compare.
    } alu_op_t;

    // ======================================================================
    // Datapath selections
    // ======================================================================

    typedef enum logic [1:0] {
        src_a_pc   = 2'd0,                     // auipc and jal add to the pc.
        src_a_zero = 2'd1,                     // lui passes the immediate through.
        src_a_reg  = 2'd2
    } src_a_t;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_mem  = 2'd1,
        wb_link = 2'd2                         // return address for jal.
    } wb_sel_t;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_kind_t;

endpackage
